//--- sim.f
+incdir+design
design/dma_misc_pkg.sv
design/reg_decode.sv
design/tim_cnt.sv
design/irq_ctl.sv
design/dma_misc_top.sv
verification/tb_clk_gen.sv
verification/dma_misc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := dma_misc_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/dma_misc_tb.sv
`timescale 1ns/1ps

`include "dma_misc_defines.svh"

module dma_misc_tb;

    localparam int MAX_CYCLES = 4000;   // tests take roughly 1000 cycles
    localparam logic [`ADDR_W-1:0] T0_START = {`BLK_TIMER, 1'b0, 2'd0};
    localparam logic [`ADDR_W-1:0] T0_COUNT = {`BLK_TIMER, 1'b0, 2'd1};
    localparam logic [`ADDR_W-1:0] T0_CTRL  = {`BLK_TIMER, 1'b0, 2'd2};
    localparam logic [`ADDR_W-1:0] T1_START = {`BLK_TIMER, 1'b1, 2'd0};
    localparam logic [`ADDR_W-1:0] T1_CTRL  = {`BLK_TIMER, 1'b1, 2'd2};
    localparam logic [`ADDR_W-1:0] IRQ_MASK_A  = {`BLK_IRQ, 3'd0};
    localparam logic [`ADDR_W-1:0] IRQ_CAUSE_A = {`BLK_IRQ, 3'd1};
    localparam logic [`DATA_W-1:0] ENA  = `DATA_W'(1) << `CTRL_ENA_BIT;
    localparam logic [`DATA_W-1:0] CONT = `DATA_W'(1) << `CTRL_CONT_BIT;

    logic                   sys_clk;
    logic                   sys_rstN;
    dma_misc_pkg::reg_bus_t reg_bus;
    logic [5:0]             chan_done;
    logic                   sys_irq;
    logic                   pio_irq;
    logic [`DATA_W-1:0]     rd_dat;
    logic                   cpu_irq;

    integer                 seed = 32'hab2b8152;
    int                     cycles = 0;
    logic                   noise = 1'b0;  // random chan_done, sys_irq, pio_irq
    logic [`ADDR_W-1:0]     addr;
    logic [`DATA_W-1:0]     val;
    int                     n;

    // reference model
    logic [`DATA_W-1:0]     m_start [2];
    logic [`DATA_W-1:0]     m_count [2];
    logic [1:0]             m_ctrl [2];
    logic                   m_run [2];
    logic                   m_halt [2];
    logic                   m_done [2];
    logic [`IRQ_SRCS-1:0]   m_mask;
    logic [`IRQ_SRCS-1:0]   m_cause;
    logic [`DATA_W-1:0]     exp_rd;

    tb_clk_gen tb_clk_gen_i (.sys_clk(sys_clk), .sys_rstN(sys_rstN));

    dma_misc_top dma_misc_top_i (
        .sys_clk(sys_clk), .sys_rstN(sys_rstN), .reg_bus(reg_bus), .chan_done(chan_done),
        .sys_irq(sys_irq), .pio_irq(pio_irq), .rd_dat(rd_dat), .cpu_irq(cpu_irq)
    );

    task automatic check_rd_dat(logic [`DATA_W-1:0] exp_val, logic [`DATA_W-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("ERROR at %0t: rd_dat expected %h, actual %h", $time, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "rd_dat mismatch");
        end
    endtask

    task automatic check_irq(logic exp_val, logic act_val);
        if (act_val !== exp_val)
        begin
            $display("ERROR at %0t: cpu_irq expected %b, actual %b", $time, exp_val, act_val);
            $display("Simulation failed");
            $fatal(1, "cpu_irq mismatch");
        end
    endtask

    function automatic logic [`DATA_W-1:0] model_read(logic [`ADDR_W-1:0] a);
        logic t;
        t = a[`TIMER_SEL_BIT];
        if (a[`ADDR_W-1:3] == `BLK_TIMER)
        begin
            case (dma_misc_pkg::timer_reg_e'(a[1:0]))
                dma_misc_pkg::TIMER_START: return m_start[t];
                dma_misc_pkg::TIMER_COUNT: return m_count[t];
                dma_misc_pkg::TIMER_CTRL:  return `DATA_W'(m_ctrl[t]);
                default:                   return '0;
            endcase
        end
        if (a == IRQ_MASK_A)
            return `DATA_W'(m_mask);
        if (a == IRQ_CAUSE_A)
            return `DATA_W'(m_cause);
        return '0;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 2; i++)
        begin
            m_start[i] = '0;
            m_count[i] = '0;
            m_ctrl[i]  = '0;
            m_run[i]   = 1'b0;
            m_halt[i]  = 1'b0;
            m_done[i]  = 1'b0;
        end
        m_mask  = '0;
        m_cause = '0;
        exp_rd  = '0;
    endtask

    // one clock edge, all updates from the values before the edge
    task automatic step_model();
        logic [`IRQ_SRCS-1:0] src;
        logic [`IRQ_SRCS-1:0] clr;
        logic                 reload;
        logic                 t;
        src = {m_done[1], m_done[0], chan_done};
        clr = '0;
        if (reg_bus.rd)
            exp_rd = model_read(reg_bus.addr);
        for (int i = 0; i < 2; i++)
        begin
            reload = m_done[i] && m_ctrl[i][`CTRL_CONT_BIT];
            m_done[i] = 1'b0;
            if (!m_ctrl[i][`CTRL_ENA_BIT])
            begin
                m_run[i]  = 1'b0;
                m_halt[i] = 1'b0;
            end
            else if (!m_run[i] && !m_halt[i])
            begin
                m_count[i] = m_start[i];    // first enabled edge
                m_run[i]   = 1'b1;
            end
            else if (m_run[i] && reload)
                m_count[i] = m_start[i];
            else if (m_run[i] && m_count[i] != 0)
            begin
                m_count[i] = m_count[i] - 1;
                m_done[i]  = (m_count[i] == 0);
                m_halt[i]  = m_done[i] && !m_ctrl[i][`CTRL_CONT_BIT];
                m_run[i]   = !m_halt[i];
            end
        end
        t = reg_bus.addr[`TIMER_SEL_BIT];
        if (reg_bus.wr && reg_bus.addr[`ADDR_W-1:3] == `BLK_TIMER)
        begin
            if (reg_bus.addr[1:0] == 2'd0)
                m_start[t] = reg_bus.wr_dat;
            if (reg_bus.addr[1:0] == 2'd2)
            begin
                m_ctrl[t][`CTRL_ENA_BIT]  = reg_bus.wr_dat[`CTRL_ENA_BIT];
                m_ctrl[t][`CTRL_CONT_BIT] = reg_bus.wr_dat[`CTRL_CONT_BIT];
            end
        end
        if (reg_bus.wr && reg_bus.addr == IRQ_MASK_A)
            m_mask = reg_bus.wr_dat[`IRQ_SRCS-1:0];
        if (reg_bus.wr && reg_bus.addr == IRQ_CAUSE_A)
            clr = ~reg_bus.wr_dat[`IRQ_SRCS-1:0];
        m_cause = (m_cause & ~clr) | src;   // a set beats a clear
    endtask

    always @(posedge sys_clk)
    begin
        if (!sys_rstN)
            clear_model();
        else
            step_model();
        #3;
        check_rd_dat(exp_rd, rd_dat);
        check_irq(sys_irq || pio_irq || (|(m_cause & m_mask)), cpu_irq);
    end

    always @(posedge sys_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic bus_cycle(logic rd, logic wr, logic [`ADDR_W-1:0] a,
                             logic [`DATA_W-1:0] dat);
        @(posedge sys_clk);
        #2;
        reg_bus.rd     = rd;
        reg_bus.wr     = wr;
        reg_bus.addr   = a;
        reg_bus.wr_dat = dat;
        chan_done = noise ? 6'($random(seed) & $random(seed) & $random(seed)) : 6'd0;
        sys_irq   = noise && (($random(seed) & 7) == 0);
        pio_irq   = noise && (($random(seed) & 7) == 0);
    endtask

    task automatic write_reg(logic [`ADDR_W-1:0] a, logic [`DATA_W-1:0] dat);
        bus_cycle(1'b0, 1'b1, a, dat);
    endtask

    task automatic idle_cycles(int count);
        repeat (count) bus_cycle(1'b0, 1'b0, '0, '0);
    endtask

    task automatic read_reg(logic [`ADDR_W-1:0] a, output logic [`DATA_W-1:0] rd_val);
        bus_cycle(1'b1, 1'b0, a, '0);
        idle_cycles(1);
        #1;
        rd_val = rd_dat;    // one cycle after the read strobe
    endtask

    task automatic stop_timers();
        write_reg(T0_CTRL, '0);
        write_reg(T1_CTRL, '0);
        idle_cycles(2);     // let a last done pulse land
        write_reg(IRQ_CAUSE_A, '0);
    endtask

    task automatic wait_cause(int bit_idx, int limit);
        logic [`DATA_W-1:0] cause_val;
        int                 waited;
        waited    = 0;
        cause_val = '0;
        while (!cause_val[bit_idx])
        begin
            if (waited > limit)
            begin
                $display("cause bit %0d did not set within %0d cycles", bit_idx, limit);
                $display("Simulation failed");
                $fatal(1, "cause bit missing");
            end
            read_reg(IRQ_CAUSE_A, cause_val);
            waited = waited + 2;
        end
    endtask

    initial
    begin
        reg_bus   = '0;
        chan_done = '0;
        sys_irq   = 1'b0;
        pio_irq   = 1'b0;
        @(posedge sys_rstN);

        // register readback over mapped and unmapped addresses
        repeat (60)
        begin
            addr = 7'($random(seed));
            if (($random(seed) & 3) != 0)
                addr[6:5] = 2'b11;
            write_reg(addr, $random(seed));
            read_reg(addr, val);
        end

        // one-shot timer 0, done lands on cause bit 6
        repeat (3)
        begin
            stop_timers();
            n = 1 + {$random(seed)} % 40;
            write_reg(T0_START, n);
            write_reg(T0_CTRL, ENA);
            idle_cycles(n + 1);
            read_reg(IRQ_CAUSE_A, val);
            check_rd_dat('0, val);
            read_reg(IRQ_CAUSE_A, val);
            check_rd_dat(`DATA_W'(1) << 6, val);
            read_reg(T0_COUNT, val);
            check_rd_dat('0, val);
        end

        // continuous timer 1 fires once per period
        stop_timers();
        n = 1 + {$random(seed)} % 20;
        write_reg(T1_START, n);
        write_reg(T1_CTRL, ENA | CONT);
        repeat (4)
        begin
            wait_cause(7, n + 4);
            write_reg(IRQ_CAUSE_A, ~(`DATA_W'(1) << 7));
        end
        stop_timers();

        // cause set and clear with random channel pulses
        noise = 1'b1;
        repeat (100)
        begin
            case ({$random(seed)} % 4)
                0:       write_reg(IRQ_CAUSE_A, $random(seed));
                1:       write_reg(IRQ_MASK_A, $random(seed));
                2:       read_reg(IRQ_CAUSE_A, val);
                default: read_reg(IRQ_MASK_A, val);
            endcase
        end

        // cpu_irq combine under random mask and cause
        repeat (40)
        begin
            write_reg(IRQ_MASK_A, $random(seed));
            write_reg(IRQ_CAUSE_A, $random(seed));
            idle_cycles(3);
        end
        noise = 1'b0;
        idle_cycles(2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rstN
);

    localparam int HALF_PERIOD = 10;    // 20 ns clock
    localparam int RST_CYCLES  = 2;

    initial
    begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD sys_clk = ~sys_clk;
    end

    initial
    begin
        sys_rstN = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        #2;
        sys_rstN = 1'b1;                // released with the stimulus offset
    end

endmodule

//--- design/dma_misc_top.sv
`timescale 1ns/1ps

`include "dma_misc_defines.svh"

module dma_misc_top (
    input  logic                     sys_clk,
    input  logic                     sys_rstN,
    input  dma_misc_pkg::reg_bus_t   reg_bus,
    input  logic [5:0]               chan_done,
    input  logic                     sys_irq,
    input  logic                     pio_irq,
    output logic [`DATA_W-1:0]       rd_dat,
    output logic                     cpu_irq
);

    dma_misc_pkg::blk_sel_t blk_sel;
    dma_misc_pkg::irq_src_t irq_src;
    logic [`DATA_W-1:0]     timer0_rd_dat;
    logic [`DATA_W-1:0]     timer1_rd_dat;
    logic [`DATA_W-1:0]     irq_rd_dat;
    logic [1:0]             timer_done;

    assign irq_src.chan_done  = chan_done;
    assign irq_src.timer_done = timer_done;

    reg_decode reg_decode_i (
        .sys_clk(sys_clk), .sys_rstN(sys_rstN), .reg_bus(reg_bus),
        .timer0_rd_dat(timer0_rd_dat), .timer1_rd_dat(timer1_rd_dat),
        .irq_rd_dat(irq_rd_dat), .blk_sel(blk_sel), .rd_dat(rd_dat)
    );

    tim_cnt timer0_i (
        .sys_clk(sys_clk), .sys_rstN(sys_rstN), .reg_bus(reg_bus),
        .sel(blk_sel.timer0), .rd_dat(timer0_rd_dat), .timer_done(timer_done[0])
    );

    tim_cnt timer1_i (
        .sys_clk(sys_clk), .sys_rstN(sys_rstN), .reg_bus(reg_bus),
        .sel(blk_sel.timer1), .rd_dat(timer1_rd_dat), .timer_done(timer_done[1])
    );

    irq_ctl irq_ctl_i (
        .sys_clk(sys_clk), .sys_rstN(sys_rstN), .reg_bus(reg_bus),
        .sel(blk_sel.irq), .irq_src(irq_src), .sys_irq(sys_irq),
        .pio_irq(pio_irq), .rd_dat(irq_rd_dat), .cpu_irq(cpu_irq)
    );

endmodule

//--- design/irq_ctl.sv
`timescale 1ns/1ps

`include "dma_misc_defines.svh"

module irq_ctl (
    input  logic                     sys_clk,
    input  logic                     sys_rstN,
    input  dma_misc_pkg::reg_bus_t   reg_bus,
    input  logic                     sel,
    input  dma_misc_pkg::irq_src_t   irq_src,
    input  logic                     sys_irq,
    input  logic                     pio_irq,
    output logic [`DATA_W-1:0]       rd_dat,
    output logic                     cpu_irq
);

    dma_misc_pkg::irq_reg_e reg_idx;
    logic [`IRQ_SRCS-1:0]   mask_q;
    logic [`IRQ_SRCS-1:0]   cause_q;
    logic [`IRQ_SRCS-1:0]   src_bits;
    logic [`IRQ_SRCS-1:0]   cause_clr;
    logic                   wr_en;

    assign reg_idx  = dma_misc_pkg::irq_reg_e'(reg_bus.addr[2:0]);
    assign wr_en    = sel && reg_bus.wr;
    assign src_bits = {irq_src.timer_done, irq_src.chan_done};

    // a 0 written to the cause register clears that bit
    assign cause_clr = (wr_en && reg_idx == dma_misc_pkg::IRQ_CAUSE) ?
                       ~reg_bus.wr_dat[`IRQ_SRCS-1:0] : '0;

    always_ff @(posedge sys_clk or negedge sys_rstN)
    begin
        if (!sys_rstN)
        begin
            mask_q <= '0;
        end
        else if (wr_en && reg_idx == dma_misc_pkg::IRQ_MASK)
        begin
            mask_q <= reg_bus.wr_dat[`IRQ_SRCS-1:0];
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rstN)
    begin
        if (!sys_rstN)
        begin
            cause_q <= '0;
        end
        else
        begin
            cause_q <= (cause_q & ~cause_clr) | src_bits;   // set beats clear
        end
    end

    always_comb
    begin
        rd_dat = '0;
        if (sel)
        begin
            case (reg_idx)
                dma_misc_pkg::IRQ_MASK:  rd_dat[`IRQ_SRCS-1:0] = mask_q;
                dma_misc_pkg::IRQ_CAUSE: rd_dat[`IRQ_SRCS-1:0] = cause_q;
                default:                 rd_dat = '0;
            endcase
        end
    end

    assign cpu_irq = sys_irq || pio_irq || |(cause_q & mask_q);

    a_cause_from_src: assert property (
        @(posedge sys_clk) disable iff (!sys_rstN)
        (cause_q & ~$past(cause_q) & ~$past(src_bits)) == '0
    );

endmodule

//--- design/tim_cnt.sv
`timescale 1ns/1ps

`include "dma_misc_defines.svh"

module tim_cnt (
    input  logic                     sys_clk,
    input  logic                     sys_rstN,
    input  dma_misc_pkg::reg_bus_t   reg_bus,
    input  logic                     sel,
    output logic [`DATA_W-1:0]       rd_dat,
    output logic                     timer_done
);

    dma_misc_pkg::timer_reg_e   reg_idx;
    dma_misc_pkg::timer_state_e state_q;
    logic [`DATA_W-1:0]         start_q;
    logic [`DATA_W-1:0]         count_q;
    logic [1:0]                 ctrl_q;
    logic                       ena;
    logic                       cont;
    logic                       wr_en;

    assign reg_idx = dma_misc_pkg::timer_reg_e'(reg_bus.addr[1:0]);
    assign wr_en   = sel && reg_bus.wr;
    assign ena     = ctrl_q[`CTRL_ENA_BIT];
    assign cont    = ctrl_q[`CTRL_CONT_BIT];

    always_ff @(posedge sys_clk or negedge sys_rstN)
    begin
        if (!sys_rstN)
        begin
            start_q <= '0;
            ctrl_q  <= '0;
        end
        else if (wr_en)
        begin
            case (reg_idx)
                dma_misc_pkg::TIMER_START: start_q <= reg_bus.wr_dat;
                dma_misc_pkg::TIMER_CTRL:
                begin
                    ctrl_q[`CTRL_ENA_BIT]  <= reg_bus.wr_dat[`CTRL_ENA_BIT];
                    ctrl_q[`CTRL_CONT_BIT] <= reg_bus.wr_dat[`CTRL_CONT_BIT];
                end
                default: ;      // count is read-only
            endcase
        end
    end

    // the first edge that sees ena in IDLE loads the start value
    always_ff @(posedge sys_clk or negedge sys_rstN)
    begin
        if (!sys_rstN)
        begin
            state_q    <= dma_misc_pkg::TIMER_IDLE;
            count_q    <= '0;
            timer_done <= 1'b0;
        end
        else
        begin
            timer_done <= 1'b0;
            if (!ena)
            begin
                state_q <= dma_misc_pkg::TIMER_IDLE;
            end
            else
            begin
                case (state_q)
                    dma_misc_pkg::TIMER_IDLE:
                    begin
                        count_q <= start_q;
                        state_q <= dma_misc_pkg::TIMER_RUN;
                    end
                    dma_misc_pkg::TIMER_RUN:
                    begin
                        if (timer_done && cont)
                        begin
                            count_q <= start_q;     // reload after done
                        end
                        else if (count_q != '0)
                        begin
                            count_q <= count_q - 1'b1;
                            if (count_q == `DATA_W'(1))
                            begin
                                timer_done <= 1'b1;
                                if (!cont)
                                begin
                                    state_q <= dma_misc_pkg::TIMER_HALT;
                                end
                            end
                        end
                    end
                    dma_misc_pkg::TIMER_HALT: ;     // wait for ena clear
                    default: state_q <= dma_misc_pkg::TIMER_IDLE;
                endcase
            end
        end
    end

    always_comb
    begin
        rd_dat = '0;
        if (sel)
        begin
            case (reg_idx)
                dma_misc_pkg::TIMER_START: rd_dat = start_q;
                dma_misc_pkg::TIMER_COUNT: rd_dat = count_q;
                dma_misc_pkg::TIMER_CTRL:
                begin
                    rd_dat[`CTRL_ENA_BIT]  = ena;
                    rd_dat[`CTRL_CONT_BIT] = cont;
                end
                default: rd_dat = '0;
            endcase
        end
    end

    a_done_single: assert property (
        @(posedge sys_clk) disable iff (!sys_rstN)
        timer_done |=> !timer_done
    );

    // idle holds the count until the enable edge loads the start value
    a_idle_hold: assert property (
        @(posedge sys_clk) disable iff (!sys_rstN)
        (state_q == dma_misc_pkg::TIMER_IDLE) |=>
            ((state_q == dma_misc_pkg::TIMER_IDLE) ? $stable(count_q)
                                                    : (count_q == $past(start_q)))
    );

endmodule

//--- design/reg_decode.sv
`timescale 1ns/1ps

`include "dma_misc_defines.svh"

module reg_decode (
    input  logic                     sys_clk,
    input  logic                     sys_rstN,
    input  dma_misc_pkg::reg_bus_t   reg_bus,
    input  logic [`DATA_W-1:0]       timer0_rd_dat,
    input  logic [`DATA_W-1:0]       timer1_rd_dat,
    input  logic [`DATA_W-1:0]       irq_rd_dat,
    output dma_misc_pkg::blk_sel_t   blk_sel,
    output logic [`DATA_W-1:0]       rd_dat
);

    logic [`ADDR_W-4:0] blk_code;
    logic               timer_blk;
    logic [`DATA_W-1:0] merged;

    assign blk_code  = reg_bus.addr[`ADDR_W-1:3];
    assign timer_blk = (blk_code == `BLK_TIMER);

    assign blk_sel.timer0 = timer_blk && !reg_bus.addr[`TIMER_SEL_BIT];
    assign blk_sel.timer1 = timer_blk && reg_bus.addr[`TIMER_SEL_BIT];
    assign blk_sel.irq    = (blk_code == `BLK_IRQ);

    // unselected blocks return 0, so a plain OR is enough
    assign merged = timer0_rd_dat | timer1_rd_dat | irq_rd_dat;

    always_ff @(posedge sys_clk or negedge sys_rstN)
    begin
        if (!sys_rstN)
        begin
            rd_dat <= '0;
        end
        else if (reg_bus.rd)
        begin
            rd_dat <= merged;   // one cycle read latency
        end
    end

    // only the selected block may answer
    a_one_sel: assert property (
        @(posedge sys_clk) disable iff (!sys_rstN)
        (!(|timer0_rd_dat) || blk_sel.timer0) &&
        (!(|timer1_rd_dat) || blk_sel.timer1) &&
        (!(|irq_rd_dat) || blk_sel.irq)
    );

endmodule

//--- design/dma_misc_pkg.sv
`include "dma_misc_defines.svh"

package dma_misc_pkg;

    // one CPU register access per cycle
    typedef struct packed {
        logic               rd;
        logic               wr;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wr_dat;
    } reg_bus_t;

    typedef enum logic [1:0] {
        TIMER_START = 2'd0,
        TIMER_COUNT = 2'd1,     // read-only live count
        TIMER_CTRL  = 2'd2
    } timer_reg_e;

    typedef enum logic [2:0] {
        IRQ_MASK  = 3'd0,
        IRQ_CAUSE = 3'd1
    } irq_reg_e;

    typedef enum logic [1:0] {
        TIMER_IDLE,
        TIMER_RUN,
        TIMER_HALT
    } timer_state_e;

    // chan_done lands on cause 0..5, timer_done on cause 6..7
    typedef struct packed {
        logic [5:0] chan_done;  // m2m, x8, f8, two each
        logic [1:0] timer_done;
    } irq_src_t;

    typedef struct packed {
        logic timer0;
        logic timer1;
        logic irq;
    } blk_sel_t;

endpackage

//--- design/dma_misc_defines.svh
`ifndef DMA_MISC_DEFINES_SVH
`define DMA_MISC_DEFINES_SVH

// register bus widths
`define DATA_W          32
`define ADDR_W          7

// interrupt controller
`define IRQ_SRCS        8

// block codes, compared with addr[6:3]
`define BLK_TIMER       4'b1110
`define BLK_IRQ         4'b1111

// addr[2] picks timer 0 or timer 1 inside the timer block
`define TIMER_SEL_BIT   2

// timer control register layout
`define CTRL_ENA_BIT    1
`define CTRL_CONT_BIT   0

`endif
